// File: verilog.f
+incdir+.
rvmem_pkg.sv
mem_arbiter.sv
clint_timer.sv
axi_rw_bridge.sv
rvmem_top.sv
tb_axi_mem.sv
tb_checker.sv
tb_rvmem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_rvmem
FILELIST  ?= verilog.f
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_rvmem.sv
// memory subsystem testbench
// clock, reset and a stimulus table applied to the fetch and load/store ports

`include "rvmem_consts.svh"

module tb_rvmem import rvmem_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] P_IFU  = 2'd0;
  localparam logic [1:0] P_LSU  = 2'd1;
  localparam logic [1:0] P_BOTH = 2'd2;

  // faddr is the fetch address used by concurrent entries
  typedef struct packed {
    logic [1:0]  port;
    logic        wen;
    logic [1:0]  size;
    logic [63:0] addr;
    logic [63:0] wdata;
    logic [63:0] faddr;
    logic        chk;
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        chk;
  mem_req_t    ifu_req;
  logic        ifu_valid;
  logic        ifu_ready;
  logic [31:0] ifu_rdata;
  mem_req_t    lsu_req;
  logic        lsu_valid;
  logic        lsu_ready;
  logic [63:0] lsu_rdata;
  axi_aw_t     aw;
  logic        aw_valid;
  logic        aw_ready;
  axi_w_t      w;
  logic        w_valid;
  logic        w_ready;
  logic        b_valid;
  logic        b_ready;
  axi_ar_t     ar;
  logic        ar_valid;
  logic        ar_ready;
  axi_r_t      r;
  logic        r_valid;
  logic        r_ready;
  logic        timer_irq;
  int          errs;
  entry_t      tbl [64];
  int          n_ent;
  int          cycles;
  int          limit;

  rvmem_top rvmem_top_inst (
    .clk(clk), .rst_n(rst_n),
    .i_ifu_req(ifu_req), .i_ifu_valid(ifu_valid), .o_ifu_ready(ifu_ready),
    .o_ifu_rdata(ifu_rdata),
    .i_lsu_req(lsu_req), .i_lsu_valid(lsu_valid), .o_lsu_ready(lsu_ready),
    .o_lsu_rdata(lsu_rdata),
    .o_aw(aw), .o_aw_valid(aw_valid), .i_aw_ready(aw_ready),
    .o_w(w), .o_w_valid(w_valid), .i_w_ready(w_ready),
    .i_b_valid(b_valid), .o_b_ready(b_ready),
    .o_ar(ar), .o_ar_valid(ar_valid), .i_ar_ready(ar_ready),
    .i_r(r), .i_r_valid(r_valid), .o_r_ready(r_ready),
    .o_timer_irq(timer_irq)
  );

  tb_axi_mem axi_mem_inst (
    .clk(clk), .rst_n(rst_n),
    .i_aw(aw), .i_aw_valid(aw_valid), .o_aw_ready(aw_ready),
    .i_w(w), .i_w_valid(w_valid), .o_w_ready(w_ready),
    .o_b_valid(b_valid), .i_b_ready(b_ready),
    .i_ar(ar), .i_ar_valid(ar_valid), .o_ar_ready(ar_ready),
    .o_r(r), .o_r_valid(r_valid), .i_r_ready(r_ready)
  );

  tb_checker checker_inst (
    .clk(clk), .rst_n(rst_n), .i_check(chk),
    .i_ifu_req(ifu_req), .i_ifu_valid(ifu_valid), .i_ifu_ready(ifu_ready),
    .i_ifu_rdata(ifu_rdata),
    .i_lsu_req(lsu_req), .i_lsu_valid(lsu_valid), .i_lsu_ready(lsu_ready),
    .i_lsu_rdata(lsu_rdata),
    .i_aw(aw), .i_aw_valid(aw_valid), .i_aw_ready(aw_ready),
    .i_w(w), .i_w_valid(w_valid), .i_w_ready(w_ready),
    .i_ar(ar), .i_ar_valid(ar_valid), .i_ar_ready(ar_ready),
    .i_b_ready(b_ready), .i_r_ready(r_ready),
    .i_irq(timer_irq), .o_errs(errs)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic add_entry(input logic [1:0] port, input logic wen, input logic [1:0] size,
                           input logic [63:0] addr, input logic [63:0] wdata,
                           input logic [63:0] faddr);
    tbl[n_ent] = '{port: port, wen: wen, size: size, addr: addr, wdata: wdata,
                   faddr: faddr, chk: 1'b1};
    n_ent++;
  endtask

  task automatic build_table();
    add_entry(P_IFU, 1'b0, `SIZE_W, 64'h000, 64'h0, 64'h0);
    add_entry(P_IFU, 1'b0, `SIZE_W, 64'h004, 64'h0, 64'h0);
    add_entry(P_IFU, 1'b0, `SIZE_W, 64'h008, 64'h0, 64'h0);
    add_entry(P_IFU, 1'b0, `SIZE_W, 64'h01c, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b1, `SIZE_D, 64'h100, 64'h1122_3344_5566_7788, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_D, 64'h100, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b1, `SIZE_W, 64'h104, 64'hdead_beef, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_D, 64'h100, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b1, `SIZE_H, 64'h10a, 64'hcafe, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_H, 64'h10a, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b1, `SIZE_B, 64'h10f, 64'h5a, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_B, 64'h10f, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b1, `SIZE_H, 64'h113, 64'hbeef, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_W, 64'h112, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b1, `SIZE_W, 64'h11a, 64'h0123_4567, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_D, 64'h118, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_B, 64'h11d, 64'h0, 64'h0);
    add_entry(P_BOTH, 1'b0, `SIZE_D, 64'h100, 64'h0, 64'h040);
    add_entry(P_BOTH, 1'b1, `SIZE_W, 64'h120, 64'h89ab_cdef, 64'h104);
    add_entry(P_LSU, 1'b0, `SIZE_D, `MTIME_ADDR, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_D, `MTIME_ADDR, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_D, `MTIMECMP_ADDR, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b1, `SIZE_D, `MTIMECMP_ADDR, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_D, `MTIMECMP_ADDR, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b1, `SIZE_D, `MTIMECMP_ADDR, '1, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_D, `MTIME_ADDR, 64'h0, 64'h0);
    add_entry(P_IFU, 1'b0, `SIZE_W, 64'h120, 64'h0, 64'h0);
    add_entry(P_LSU, 1'b1, `SIZE_D, 64'h200, 64'h0f1e_2d3c_4b5a_6978, 64'h0);
    add_entry(P_LSU, 1'b0, `SIZE_W, 64'h204, 64'h0, 64'h0);
    add_entry(P_IFU, 1'b0, `SIZE_W, 64'h200, 64'h0, 64'h0);
  endtask

  // holds each request until its ready, sampled mid-cycle
  task automatic run_entry(input entry_t e);
    logic lsu_got;
    logic ifu_got;
    @(negedge clk);
    lsu_got = (e.port == P_IFU);
    ifu_got = (e.port == P_LSU);
    chk = e.chk;
    if (!lsu_got) begin
      lsu_req   = '{addr: e.addr, wdata: e.wdata, size: e.size, wen: e.wen};
      lsu_valid = 1'b1;
    end
    if (!ifu_got) begin
      ifu_req   = '{addr: (e.port == P_IFU) ? e.addr : e.faddr, wdata: '0,
                    size: `SIZE_W, wen: 1'b0};
      ifu_valid = 1'b1;
    end
    while (!(lsu_got && ifu_got)) begin
      @(negedge clk);
      if (lsu_ready) begin
        lsu_got   = 1'b1;
        lsu_valid = 1'b0;
      end
      if (ifu_ready) begin
        ifu_got   = 1'b1;
        ifu_valid = 1'b0;
      end
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run went past %0d cycles", limit);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    int errs_before;
    int passes;
    int fails;
    rst_n     = 1'b0;
    chk       = 1'b0;
    ifu_req   = '0;
    ifu_valid = 1'b0;
    lsu_req   = '0;
    lsu_valid = 1'b0;
    n_ent     = 0;
    cycles    = 0;
    passes    = 0;
    fails     = 0;
    build_table();
    limit = n_ent * 40 + 200;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int k = 0; k < n_ent; k++) begin
      errs_before = errs;
      run_entry(tbl[k]);
      if (errs == errs_before) begin
        passes++;
      end else begin
        fails++;
      end
      $display("test %0d: %s", k, (errs == errs_before) ? "pass" : "fail");
    end
    repeat (6) @(negedge clk);
    $display("%0d tests passed, %0d failed, %0d errors", passes, fails, errs);
    if (errs == 0 && fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: tb_checker.sv
// response checker
// shadow memory, timer rules, priority order and AXI hold checks

`include "rvmem_consts.svh"

module tb_checker import rvmem_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_check,
  input  mem_req_t    i_ifu_req,
  input  logic        i_ifu_valid,
  input  logic        i_ifu_ready,
  input  logic [31:0] i_ifu_rdata,
  input  mem_req_t    i_lsu_req,
  input  logic        i_lsu_valid,
  input  logic        i_lsu_ready,
  input  logic [63:0] i_lsu_rdata,
  input  axi_aw_t     i_aw,
  input  logic        i_aw_valid,
  input  logic        i_aw_ready,
  input  axi_w_t      i_w,
  input  logic        i_w_valid,
  input  logic        i_w_ready,
  input  axi_ar_t     i_ar,
  input  logic        i_ar_valid,
  input  logic        i_ar_ready,
  input  logic        i_b_ready,
  input  logic        i_r_ready,
  input  logic        i_irq,
  output int          o_errs
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]  shadow [0:4095];
  logic [63:0] tcmp;
  logic [63:0] last_time;
  logic [63:0] exp_data;
  logic [7:0]  exp_strb;
  logic        time_seen;
  logic        tcmp_written;
  logic        irq_pend;
  logic        irq_exp;
  logic        lsu_q;
  logic        ifu_q;
  logic        lsu_busy;
  logic        tmr_act;
  logic        is_tmr;
  axi_aw_t     aw_q;
  axi_w_t      w_q;
  axi_ar_t     ar_q;
  logic        awv_q;
  logic        awr_q;
  logic        wv_q;
  logic        wr_q;
  logic        arv_q;
  logic        arr_q;
  int          irq_cnt;
  int          cyc;
  int          lsu_start;
  int          ifu_start;
  int          tmr_cnt;

  assign is_tmr = (i_lsu_req.addr == `MTIME_ADDR) || (i_lsu_req.addr == `MTIMECMP_ADDR);

  function automatic logic [63:0] read_shadow(input logic [11:0] a, input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = v | (64'(shadow[a + 12'(i)]) << (8 * i));
    end
    return v;
  endfunction

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    o_errs++;
  endtask

  task automatic rule_error(input string what);
    $display("%0t error: %s", $time, what);
    o_errs++;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      // start from the slave model's preload
      for (int i = 0; i < 512; i++) begin
        for (int b = 0; b < 8; b++) begin
          shadow[12'(i * 8 + b)] = 8'(tb_rvmem.axi_mem_inst.mem[9'(i)] >> (8 * b));
        end
      end
      o_errs = 0;
      tcmp = '1;
      time_seen = 1'b0;
      tcmp_written = 1'b0;
      irq_pend = 1'b0;
      lsu_busy = 1'b0;
      tmr_act = 1'b0;
      cyc = 0;
      if (i_irq) begin
        rule_error("timer interrupt high during reset");
      end
    end else begin
      cyc++;
      // handshake outputs and the interrupt idle low out of reset
      if (cyc == 1 && {i_ifu_ready, i_lsu_ready, i_aw_valid, i_w_valid, i_ar_valid,
                       i_b_ready, i_r_ready, i_irq} !== 8'h00) begin
        rule_error("a ready, valid or interrupt output is not low after reset");
      end
      if (!tcmp_written && i_irq) begin
        rule_error("timer interrupt high before mtimecmp was written");
      end
      if (irq_pend) begin
        if (i_irq == irq_exp) begin
          irq_pend = 1'b0;
        end else if (irq_cnt == 0) begin
          value_error("o_timer_irq", 64'(i_irq), 64'(irq_exp));
          irq_pend = 1'b0;
        end else begin
          irq_cnt--;
        end
      end
      if (awv_q && !awr_q && (!i_aw_valid || i_aw != aw_q)) begin
        rule_error("AW valid or payload changed before its handshake");
      end
      if (wv_q && !wr_q && (!i_w_valid || i_w != w_q)) begin
        rule_error("W valid or payload changed before its handshake");
      end
      if (arv_q && !arr_q && (!i_ar_valid || i_ar != ar_q)) begin
        rule_error("AR valid or payload changed before its handshake");
      end
      if (i_aw_valid && i_aw_ready) begin
        if (i_aw.addr != i_lsu_req.addr) begin
          value_error("o_aw.addr", i_aw.addr, i_lsu_req.addr);
        end
        if (i_aw.size != {1'b0, i_lsu_req.size}) begin
          value_error("o_aw.size", 64'(i_aw.size), 64'(i_lsu_req.size));
        end
      end
      if (i_ar_valid && i_ar_ready && lsu_busy) begin
        if (i_ar.addr != i_lsu_req.addr) begin
          value_error("o_ar.addr", i_ar.addr, i_lsu_req.addr);
        end
        if (i_ar.size != {1'b0, i_lsu_req.size}) begin
          value_error("o_ar.size", 64'(i_ar.size), 64'(i_lsu_req.size));
        end
      end
      if (i_w_valid && i_w_ready) begin
        // one strobe bit per byte the store touches
        exp_strb = '0;
        for (int i = 0; i < (1 << i_lsu_req.size); i++) begin
          exp_strb[i_lsu_req.addr[2:0] + 3'(i)] = 1'b1;
        end
        if (i_w.strb != exp_strb) begin
          value_error("o_w.strb", 64'(i_w.strb), 64'(exp_strb));
        end
        if (!i_w.last) begin
          value_error("o_w.last", 64'(i_w.last), 64'd1);
        end
      end
      if (i_lsu_valid && !lsu_q) begin
        lsu_busy = 1'b1;
        lsu_start = cyc;
        tmr_act = is_tmr;
        tmr_cnt = 0;
      end else if (tmr_act) begin
        tmr_cnt++;
      end
      if (tmr_act && (i_aw_valid || i_w_valid || i_ar_valid)) begin
        rule_error("AXI valid raised during a timer access");
      end
      if (i_ifu_valid && !ifu_q) begin
        ifu_start = cyc;
      end
      if (i_lsu_ready) begin
        if (tmr_act && tmr_cnt != 2) begin
          rule_error($sformatf("timer access took %0d cycles instead of 2", tmr_cnt));
        end
        lsu_busy = 1'b0;
        tmr_act = 1'b0;
        if (i_lsu_req.wen) begin
          if (i_lsu_req.addr == `MTIMECMP_ADDR) begin
            tcmp = i_lsu_req.wdata;
            tcmp_written = 1'b1;
            irq_pend = (tcmp == '0) || (tcmp == '1);
            irq_exp = (tcmp == '0);
            irq_cnt = 3;
          end else if (!is_tmr) begin
            for (int i = 0; i < (1 << i_lsu_req.size); i++) begin
              shadow[i_lsu_req.addr[11:0] + 12'(i)] = 8'(i_lsu_req.wdata >> (8 * i));
            end
          end
        end else if (i_check) begin
          if (i_lsu_req.addr == `MTIME_ADDR) begin
            if (time_seen && i_lsu_rdata <= last_time) begin
              rule_error("mtime did not increase between two reads");
            end
            last_time = i_lsu_rdata;
            time_seen = 1'b1;
          end else if (i_lsu_req.addr == `MTIMECMP_ADDR) begin
            if (i_lsu_rdata != tcmp) begin
              value_error("o_lsu_rdata", i_lsu_rdata, tcmp);
            end
          end else begin
            exp_data = read_shadow(i_lsu_req.addr[11:0], 1 << i_lsu_req.size);
            if (i_lsu_rdata != exp_data) begin
              value_error("o_lsu_rdata", i_lsu_rdata, exp_data);
            end
          end
        end
      end
      if (i_ifu_ready) begin
        if (lsu_busy && lsu_start <= ifu_start) begin
          rule_error("fetch completed ahead of an earlier load/store");
        end
        exp_data = read_shadow({i_ifu_req.addr[11:2], 2'b00}, 4);
        if (i_check && 64'(i_ifu_rdata) != exp_data) begin
          value_error("o_ifu_rdata", 64'(i_ifu_rdata), exp_data);
        end
      end
    end
    lsu_q = i_lsu_valid;
    ifu_q = i_ifu_valid;
    aw_q  = i_aw;
    w_q   = i_w;
    ar_q  = i_ar;
    awv_q = i_aw_valid;
    awr_q = i_aw_ready;
    wv_q  = i_w_valid;
    wr_q  = i_w_ready;
    arv_q = i_ar_valid;
    arr_q = i_ar_ready;
  end

endmodule

// File: tb_axi_mem.sv
// AXI slave memory model
// 4 KiB memory preloaded from an LFSR, random 0 to 3 wait cycles per handshake

`include "rvmem_consts.svh"

module tb_axi_mem import rvmem_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  axi_aw_t i_aw,
  input  logic    i_aw_valid,
  output logic    o_aw_ready = 1'b0,
  input  axi_w_t  i_w,
  input  logic    i_w_valid,
  output logic    o_w_ready = 1'b0,
  output logic    o_b_valid = 1'b0,
  input  logic    i_b_ready,
  input  axi_ar_t i_ar,
  input  logic    i_ar_valid,
  output logic    o_ar_ready = 1'b0,
  output axi_r_t  o_r = '0,
  output logic    o_r_valid = 1'b0,
  input  logic    i_r_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [63:0] mem [0:511];
  logic [31:0] lfsr = 32'hd51b;
  logic        aw_fire;
  logic        w_fire;
  logic        ar_fire;
  logic        r_fire;
  logic        b_fire;
  logic [63:0] aw_addr_q;
  logic [63:0] ar_addr_q;
  axi_w_t      w_q;
  logic        aw_got;
  logic        w_got;
  logic        rd_pend;
  logic        wr_pend;
  logic [63:0] lane_mask;
  int          aw_wait;
  int          w_wait;
  int          ar_wait;
  int          rsp_wait;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  // two LFSR bits give a wait of 0 to 3 cycles
  task automatic draw_wait(output int n);
    n = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_next(lfsr);
      n = n * 2 + int'(lfsr[0]);
    end
  endtask

  task automatic pace_ready(input logic valid, input logic fire, inout logic rdy,
                            inout int cnt);
    if (fire) begin
      rdy = 1'b0;
      draw_wait(cnt);
    end else if (valid && !rdy) begin
      if (cnt == 0) begin
        rdy = 1'b1;
      end else begin
        cnt--;
      end
    end
  endtask

  initial begin
    for (int i = 0; i < 512; i++) begin
      for (int b = 0; b < 64; b++) begin
        lfsr = lfsr_next(lfsr);
        mem[9'(i)][6'(b)] = lfsr[0];
      end
    end
  end

  always @(posedge clk) begin
    aw_fire <= i_aw_valid && o_aw_ready;
    w_fire  <= i_w_valid && o_w_ready;
    ar_fire <= i_ar_valid && o_ar_ready;
    r_fire  <= o_r_valid && i_r_ready;
    b_fire  <= o_b_valid && i_b_ready;
    if (i_aw_valid && o_aw_ready) begin
      aw_addr_q <= i_aw.addr;
    end
    if (i_w_valid && o_w_ready) begin
      w_q <= i_w;
    end
    if (i_ar_valid && o_ar_ready) begin
      ar_addr_q <= i_ar.addr;
    end
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      o_aw_ready = 1'b0;
      o_w_ready  = 1'b0;
      o_ar_ready = 1'b0;
      o_b_valid  = 1'b0;
      o_r_valid  = 1'b0;
      aw_got     = 1'b0;
      w_got      = 1'b0;
      rd_pend    = 1'b0;
      wr_pend    = 1'b0;
      aw_wait    = 0;
      w_wait     = 0;
      ar_wait    = 0;
      rsp_wait   = 0;
    end else begin
      pace_ready(i_aw_valid, aw_fire, o_aw_ready, aw_wait);
      pace_ready(i_w_valid, w_fire, o_w_ready, w_wait);
      pace_ready(i_ar_valid, ar_fire, o_ar_ready, ar_wait);
      aw_got = aw_got || aw_fire;
      w_got  = w_got || w_fire;
      if (ar_fire) begin
        o_r.data = mem[ar_addr_q[11:3]];
        o_r.last = 1'b1;
        rd_pend  = 1'b1;
        draw_wait(rsp_wait);
      end
      // byte lanes merged under the strobe
      if (aw_got && w_got) begin
        lane_mask = '0;
        for (int b = 0; b < 8; b++) begin
          if (w_q.strb[3'(b)]) begin
            lane_mask = lane_mask | (64'hff << (8 * b));
          end
        end
        mem[aw_addr_q[11:3]] = (mem[aw_addr_q[11:3]] & ~lane_mask) | (w_q.data & lane_mask);
        aw_got  = 1'b0;
        w_got   = 1'b0;
        wr_pend = 1'b1;
        draw_wait(rsp_wait);
      end
      if (r_fire) begin
        o_r_valid = 1'b0;
        rd_pend   = 1'b0;
      end else if (rd_pend && !o_r_valid) begin
        if (rsp_wait == 0) begin
          o_r_valid = 1'b1;
        end else begin
          rsp_wait--;
        end
      end
      if (b_fire) begin
        o_b_valid = 1'b0;
        wr_pend   = 1'b0;
      end else if (wr_pend && !o_b_valid) begin
        if (rsp_wait == 0) begin
          o_b_valid = 1'b1;
        end else begin
          rsp_wait--;
        end
      end
    end
  end

endmodule

// File: rvmem_top.sv
// memory subsystem top
// fetch and load/store ports through the arbiter to the timer and AXI master

`include "rvmem_consts.svh"

module rvmem_top import rvmem_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,

  input  mem_req_t            i_ifu_req,
  input  logic                i_ifu_valid,
  output logic                o_ifu_ready,
  output logic [`FETCH_W-1:0] o_ifu_rdata,

  input  mem_req_t            i_lsu_req,
  input  logic                i_lsu_valid,
  output logic                o_lsu_ready,
  output logic [`XLEN-1:0]    o_lsu_rdata,

  output axi_aw_t             o_aw,
  output logic                o_aw_valid,
  input  logic                i_aw_ready,
  output axi_w_t              o_w,
  output logic                o_w_valid,
  input  logic                i_w_ready,
  input  logic                i_b_valid,
  output logic                o_b_ready,
  output axi_ar_t             o_ar,
  output logic                o_ar_valid,
  input  logic                i_ar_ready,
  input  axi_r_t              i_r,
  input  logic                i_r_valid,
  output logic                o_r_ready,

  output logic                o_timer_irq
);

  mem_req_t         tmr_req;
  logic             tmr_valid;
  logic [`XLEN-1:0] tmr_rdata;
  mem_req_t         ram_req;
  logic             ram_valid;
  logic             ram_ready;
  logic [`XLEN-1:0] ram_rdata;

  mem_arbiter mem_arbiter_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_ifu_req   (i_ifu_req),
    .i_ifu_valid (i_ifu_valid),
    .o_ifu_ready (o_ifu_ready),
    .o_ifu_rdata (o_ifu_rdata),
    .i_lsu_req   (i_lsu_req),
    .i_lsu_valid (i_lsu_valid),
    .o_lsu_ready (o_lsu_ready),
    .o_lsu_rdata (o_lsu_rdata),
    .o_tmr_req   (tmr_req),
    .o_tmr_valid (tmr_valid),
    .i_tmr_rdata (tmr_rdata),
    .o_ram_req   (ram_req),
    .o_ram_valid (ram_valid),
    .i_ram_ready (ram_ready),
    .i_ram_rdata (ram_rdata)
  );

  clint_timer clint_timer_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_req   (tmr_req),
    .i_valid (tmr_valid),
    .o_rdata (tmr_rdata),
    .o_irq   (o_timer_irq)
  );

  axi_rw_bridge axi_rw_bridge_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_req      (ram_req),
    .i_valid    (ram_valid),
    .o_ready    (ram_ready),
    .o_rdata    (ram_rdata),
    .o_aw       (o_aw),
    .o_aw_valid (o_aw_valid),
    .i_aw_ready (i_aw_ready),
    .o_w        (o_w),
    .o_w_valid  (o_w_valid),
    .i_w_ready  (i_w_ready),
    .i_b_valid  (i_b_valid),
    .o_b_ready  (o_b_ready),
    .o_ar       (o_ar),
    .o_ar_valid (o_ar_valid),
    .i_ar_ready (i_ar_ready),
    .i_r        (i_r),
    .i_r_valid  (i_r_valid),
    .o_r_ready  (o_r_ready)
  );

endmodule

// File: axi_rw_bridge.sv
// read/write to AXI master bridge
// single-beat transfers, byte-lane alignment and write strobes from size

`include "rvmem_consts.svh"

module axi_rw_bridge import rvmem_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,

  input  mem_req_t         i_req,
  input  logic             i_valid,
  output logic             o_ready,
  output logic [`XLEN-1:0] o_rdata,

  output axi_aw_t          o_aw,
  output logic             o_aw_valid,
  input  logic             i_aw_ready,

  output axi_w_t           o_w,
  output logic             o_w_valid,
  input  logic             i_w_ready,

  input  logic             i_b_valid,
  output logic             o_b_ready,

  output axi_ar_t          o_ar,
  output logic             o_ar_valid,
  input  logic             i_ar_ready,

  input  axi_r_t           i_r,
  input  logic             i_r_valid,
  output logic             o_r_ready
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_ADDR = 2'd1;
  localparam logic [1:0] S_DATA = 2'd2;
  localparam logic [1:0] S_RESP = 2'd3;

  logic [1:0]             state;
  logic                   aw_done;
  logic                   w_done;
  logic [2:0]             off;
  logic [`AXI_STRB_W-1:0] size_mask;
  logic [`XLEN-1:0]       data_mask;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   ar_hs;
  logic                   r_hs;
  logic                   b_hs;

  assign off = i_req.addr[2:0];

  always_comb begin
    case (i_req.size)
      `SIZE_B: size_mask = 8'h01;
      `SIZE_H: size_mask = 8'h03;
      `SIZE_W: size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // byte mask expanded to bits, used on read data
  always_comb begin
    for (int i = 0; i < `AXI_STRB_W; i++) begin
      data_mask[i*8 +: 8] = {8{size_mask[i]}};
    end
  end

  always_comb begin
    o_aw.addr = i_req.addr;
    o_aw.size = {1'b0, i_req.size};
    o_ar.addr = i_req.addr;
    o_ar.size = {1'b0, i_req.size};
    o_w.data  = i_req.wdata << {off, 3'b000};
    o_w.strb  = size_mask << off;
    o_w.last  = 1'b1;
  end

  assign o_ar_valid = (state == S_ADDR) && !i_req.wen;
  assign o_aw_valid = (state == S_ADDR) && i_req.wen && !aw_done;
  assign o_w_valid  = (state == S_ADDR) && i_req.wen && !w_done;
  assign o_r_ready  = (state == S_DATA);
  assign o_b_ready  = (state == S_RESP);

  assign aw_hs = o_aw_valid && i_aw_ready;
  assign w_hs  = o_w_valid && i_w_ready;
  assign ar_hs = o_ar_valid && i_ar_ready;
  assign r_hs  = i_r_valid && o_r_ready;
  assign b_hs  = i_b_valid && o_b_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
      o_ready <= 1'b0;
    end else begin
      o_ready <= 1'b0;
      case (state)
        S_IDLE: begin
          // valid is still up in the ready cycle, skip it
          if (i_valid && !o_ready) begin
            state <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (i_req.wen) begin
            if (aw_hs) begin
              aw_done <= 1'b1;
            end
            if (w_hs) begin
              w_done <= 1'b1;
            end
            if ((aw_done || aw_hs) && (w_done || w_hs)) begin
              state   <= S_RESP;
              aw_done <= 1'b0;
              w_done  <= 1'b0;
            end
          end else if (ar_hs) begin
            state <= S_DATA;
          end
        end
        S_DATA: begin
          if (r_hs) begin
            state   <= S_IDLE;
            o_ready <= 1'b1;
          end
        end
        default: begin
          if (b_hs) begin
            state   <= S_IDLE;
            o_ready <= 1'b1;
          end
        end
      endcase
    end
  end

  // lane shifted down to bit 0, then cut to the access size
  always_ff @(posedge clk) begin
    if (r_hs) begin
      o_rdata <= (i_r.data >> {off, 3'b000}) & data_mask;
    end
  end

endmodule

// File: clint_timer.sv
// machine timer
// memory-mapped mtime and mtimecmp with a registered timer interrupt

`include "rvmem_consts.svh"

module clint_timer import rvmem_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  mem_req_t         i_req,
  input  logic             i_valid,
  output logic [`XLEN-1:0] o_rdata,
  output logic             o_irq
);

  logic [`XLEN-1:0] mtime;
  logic [`XLEN-1:0] mtimecmp;
  logic             sel_mtime;
  logic             sel_mtimecmp;
  logic             wr;

  assign sel_mtime    = (i_req.addr == `MTIME_ADDR);
  assign sel_mtimecmp = (i_req.addr == `MTIMECMP_ADDR);
  assign wr           = i_valid && i_req.wen;

  always_comb begin
    o_rdata = '0;
    if (sel_mtime) begin
      o_rdata = mtime;
    end else if (sel_mtimecmp) begin
      o_rdata = mtimecmp;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtime    <= '0;
      mtimecmp <= '1;
      o_irq    <= 1'b0;
    end else begin
      // a write to mtime replaces this cycle's increment
      if (wr && sel_mtime) begin
        mtime <= i_req.wdata;
      end else begin
        mtime <= mtime + 1'b1;
      end
      if (wr && sel_mtimecmp) begin
        mtimecmp <= i_req.wdata;
      end
      o_irq <= (mtime >= mtimecmp);
    end
  end

endmodule

// File: mem_arbiter.sv
// memory arbiter
// shares one memory path between fetch and load/store, load/store first,
// and routes the granted access to the timer or to the AXI bridge

`include "rvmem_consts.svh"

module mem_arbiter import rvmem_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,

  input  mem_req_t            i_ifu_req,
  input  logic                i_ifu_valid,
  output logic                o_ifu_ready,
  output logic [`FETCH_W-1:0] o_ifu_rdata,

  input  mem_req_t            i_lsu_req,
  input  logic                i_lsu_valid,
  output logic                o_lsu_ready,
  output logic [`XLEN-1:0]    o_lsu_rdata,

  output mem_req_t            o_tmr_req,
  output logic                o_tmr_valid,
  input  logic [`XLEN-1:0]    i_tmr_rdata,

  output mem_req_t            o_ram_req,
  output logic                o_ram_valid,
  input  logic                i_ram_ready,
  input  logic [`XLEN-1:0]    i_ram_rdata
);

  localparam logic [1:0] OWN_NONE = 2'd0;
  localparam logic [1:0] OWN_IFU  = 2'd1;
  localparam logic [1:0] OWN_LSU  = 2'd2;

  logic [1:0]       owner;
  logic             to_tmr;
  logic             tmr_rsp;
  logic [`XLEN-1:0] tmr_rdata_q;
  mem_req_t         ifu_dw_req;
  mem_req_t         win_req;
  mem_req_t         cur_req;
  logic             is_tmr_addr;
  logic             done;
  logic [`XLEN-1:0] rsp_data;

  // fetch goes out as an aligned doubleword read, word picked on return
  always_comb begin
    ifu_dw_req      = i_ifu_req;
    ifu_dw_req.addr = {i_ifu_req.addr[`ADDR_W-1:3], 3'b000};
    ifu_dw_req.size = `SIZE_D;
    ifu_dw_req.wen  = 1'b0;
  end

  assign win_req     = i_lsu_valid ? i_lsu_req : ifu_dw_req;
  assign is_tmr_addr = (win_req.addr == `MTIME_ADDR) || (win_req.addr == `MTIMECMP_ADDR);

  assign cur_req = (owner == OWN_LSU) ? i_lsu_req : ifu_dw_req;

  assign o_tmr_req   = cur_req;
  assign o_tmr_valid = (owner != OWN_NONE) && to_tmr && !tmr_rsp;
  assign o_ram_req   = cur_req;
  assign o_ram_valid = (owner != OWN_NONE) && !to_tmr;

  assign done     = to_tmr ? tmr_rsp : i_ram_ready;
  assign rsp_data = to_tmr ? tmr_rdata_q : i_ram_rdata;

  assign o_lsu_ready = (owner == OWN_LSU) && done;
  assign o_ifu_ready = (owner == OWN_IFU) && done;
  assign o_lsu_rdata = rsp_data;
  assign o_ifu_rdata = i_ifu_req.addr[2] ? rsp_data[`FETCH_W +: `FETCH_W]
                                         : rsp_data[`FETCH_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owner   <= OWN_NONE;
      to_tmr  <= 1'b0;
      tmr_rsp <= 1'b0;
    end else if (owner == OWN_NONE) begin
      if (i_lsu_valid) begin
        owner <= OWN_LSU;
      end else if (i_ifu_valid) begin
        owner <= OWN_IFU;
      end
      to_tmr <= is_tmr_addr;
    end else if (done) begin
      owner   <= OWN_NONE;
      tmr_rsp <= 1'b0;
    end else if (to_tmr) begin
      // timer answers one cycle after it is selected
      tmr_rsp <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (o_tmr_valid) begin
      tmr_rdata_q <= i_tmr_rdata;
    end
  end

endmodule

// File: rvmem_pkg.sv
// rvmem types
// request and AXI channel payload structs shared by the memory path

`include "rvmem_consts.svh"

package rvmem_pkg;

  // one memory access from a requester
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`XLEN-1:0]   wdata;
    logic [1:0]         size;
    logic               wen;
  } mem_req_t;

  typedef struct packed {
    logic [`ADDR_W-1:0]     addr;
    logic [`AXI_SIZE_W-1:0] size;
  } axi_aw_t;

  typedef struct packed {
    logic [`XLEN-1:0]       data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } axi_w_t;

  typedef struct packed {
    logic [`ADDR_W-1:0]     addr;
    logic [`AXI_SIZE_W-1:0] size;
  } axi_ar_t;

  // no resp field since the master ignores the response code
  typedef struct packed {
    logic [`XLEN-1:0] data;
    logic             last;
  } axi_r_t;

endpackage

// File: rvmem_consts.svh
// rvmem shared constants
// data and address widths, timer register addresses, size and AXI encodings

`ifndef RVMEM_CONSTS_SVH
`define RVMEM_CONSTS_SVH

`define XLEN          64
`define ADDR_W        64
`define FETCH_W       32

// memory-mapped timer registers
`define MTIME_ADDR    64'h0000_0000_0200_bff8
`define MTIMECMP_ADDR 64'h0000_0000_0200_4000

// access size codes where bytes = 1 << size
`define SIZE_B        2'd0
`define SIZE_H        2'd1
`define SIZE_W        2'd2
`define SIZE_D        2'd3

`define AXI_SIZE_W    3
`define AXI_STRB_W    (`XLEN / 8)
// single-beat INCR with id 0 as assumed by the slave side
`define AXI_LEN_SINGLE 8'd0
`define AXI_BURST_INCR 2'b01

`endif
